//--- fetch_core_input.txt
# W address data: program word in hex. R channels strobe: run, strobe is the wait cycle of a busy run strobe (0 none)
# E channel register value: expected register contents in hex after the last run
# LDC r1, LDC r2, ADD r3=r1+r2, MOV r4=r3, ADD r5=r4+r4, STOP, then LDC r6 that must not run
# Constant 09E3 decodes as ADD r7=r1+r1, so r7 stays zero only if the constant is skipped
W 0 0021
W 1 09E3
W 2 0041
W 3 F8A5
W 4 1163
W 5 0382
W 6 24A3
W 7 0004
W 8 00C1
W 9 DEAD
R 4 0
E 0 1 09E3
E 0 3 0288
E 0 5 0510
E 0 6 0000
E 0 7 0000
E 3 2 F8A5
E 3 4 0288
E 3 5 0510
# New constants and ADD r5=r5+r4 on two channels with a run strobe while busy
W 1 0100
W 3 0023
W 6 25A3
R 2 9
E 0 3 0123
E 0 5 0633
E 0 7 0000
E 1 2 0023
E 1 5 0633
E 2 3 0288
E 3 5 0510
# Original program again on one channel
W 1 09E3
W 3 F8A5
W 6 24A3
R 1 0
E 0 3 0288
E 0 5 0510
E 0 6 0000
E 1 5 0633
# STOP moved up to word 4, so r3 and r5 keep their old values
W 4 0004
R 3 0
E 1 1 09E3
E 1 3 0123
E 1 5 0633
E 2 5 0510

//--- flist.f
fcore_pkg.sv
program_memory.sv
program_sequencer.sv
instruction_prefetcher.sv
channel_register_file.sv
fetch_core_top.sv
tb_clock_gen.sv
fetch_core_checker.sv
tb_fetch_core.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_fetch_core
FLIST      := flist.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert
PASS_TEXT  := TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_fetch_core.sv
// Testbench top that replays the input records against the fetch core and checks the registers
`timescale 1ns/1ps

module tb_fetch_core;

    localparam int program_depth = fcore_pkg::DEFAULT_PROGRAM_DEPTH;
    localparam int max_channels  = fcore_pkg::DEFAULT_MAX_CHANNELS;
    localparam int addr_width    = $clog2(program_depth);
    localparam int channel_width = $clog2(max_channels);
    localparam int count_width   = $clog2(max_channels + 1);

    // Cycles allowed on top of program length times channel count
    localparam int done_margin   = 16;
    // Longest random idle gap before a run
    localparam int max_gap       = 4;
    // Cycles watched after done for a second pulse
    localparam int settle_cycles = 8;
    localparam string input_file = "fetch_core_input.txt";

    logic                     clock;
    logic                     rst_n;
    logic                     prog_write;
    logic [addr_width-1:0]    prog_address;
    fcore_pkg::word_t         prog_data;
    logic                     run;
    logic [count_width-1:0]   n_channels;
    logic                     done;
    logic [channel_width-1:0] read_channel;
    fcore_pkg::reg_index_t    read_register;
    fcore_pkg::word_t         read_data;

    int mismatch_errors = 0;
    int done_errors     = 0;
    int other_errors    = 0;
    int cycle_count     = 0;
    int cycle_limit     = 0;

    tb_clock_gen #(
        .reset_cycles (2)
    ) u_clock_gen (
        .clock        (clock),
        .rst_n        (rst_n)
    );

    fetch_core_top #(
        .program_depth (program_depth),
        .max_channels  (max_channels)
    ) uut (
        .clock         (clock),
        .rst_n         (rst_n),
        .prog_write    (prog_write),
        .prog_address  (prog_address),
        .prog_data     (prog_data),
        .run           (run),
        .n_channels    (n_channels),
        .done          (done),
        .read_channel  (read_channel),
        .read_register (read_register),
        .read_data     (read_data)
    );

    task automatic report_counts();
        $display("Errors: %0d register mismatches, %0d done failures, %0d other failures",
                 mismatch_errors, done_errors, other_errors);
    endtask

    // Global watchdog, armed once the budget for the whole file is known
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Watchdog expired after %0d cycles, the run did not complete", cycle_count);
            report_counts();
            $display("TEST FAILED");
            $finish;
        end
    end

    // Every record costs a known worst case, a run the longest possible sweep
    task automatic compute_cycle_limit();
        int    fd;
        int    budget;
        string line;
        budget = 8;
        fd = $fopen(input_file, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                case (line.getc(0))
                    "W", "E": budget += 2;
                    "R": budget += max_gap + 2 + program_depth * max_channels
                                   + done_margin + settle_cycles;
                    default: budget += 0;
                endcase
            end
            $fclose(fd);
        end
        cycle_limit = budget;
    endtask

    task automatic load_word(input int address, input int data);
        @(negedge clock);
        prog_write   = 1'b1;
        prog_address = addr_width'(address);
        prog_data    = fcore_pkg::word_t'(data);
        @(negedge clock);
        prog_write   = 1'b0;
    endtask

    // Random idle cycles, then a one-cycle run strobe
    task automatic start_run(input int channels);
        int gap;
        gap = int'($urandom % (max_gap + 1));
        repeat (gap) @(negedge clock);
        @(negedge clock);
        n_channels = count_width'(channels);
        run        = 1'b1;
        @(negedge clock);
        run        = 1'b0;
    endtask

    // Waits for done within the limit and checks that it pulses once,
    // optionally strobing run again while the core is still busy
    task automatic compare_done(input int limit, input int strobe_at);
        int waited;
        int pulses;
        waited = 0;
        pulses = 0;
        while (pulses == 0 && waited < limit) begin
            @(negedge clock);
            waited++;
            if (done) begin
                pulses++;
            end
            run = (waited == strobe_at) && (pulses == 0);
        end
        run = 1'b0;
        if (pulses == 0) begin
            $display("done did not arrive within %0d cycles of the run strobe", limit);
            done_errors++;
        end else begin
            repeat (settle_cycles) begin
                @(negedge clock);
                if (done) begin
                    pulses++;
                end
            end
            if (pulses != 1) begin
                $display("done pulsed %0d times for a single run", pulses);
                done_errors++;
            end
        end
    endtask

    task automatic compare_word(
        input fcore_pkg::word_t actual,
        input fcore_pkg::word_t expected,
        input int               channel,
        input int               register_index
    );
        if (actual !== expected) begin
            $display("MISMATCH read_data channel %0d register %0d: got 0x%04h, expected 0x%04h",
                     channel, register_index, actual, expected);
            mismatch_errors++;
        end
    endtask

    // Readback is combinational, sampled one falling edge after the address is set
    task automatic check_register(
        input int               channel,
        input int               register_index,
        input fcore_pkg::word_t expected
    );
        @(negedge clock);
        read_channel  = channel_width'(channel);
        read_register = fcore_pkg::reg_index_t'(register_index);
        @(negedge clock);
        compare_word(read_data, expected, channel, register_index);
    endtask

    initial begin
        int    fd;
        int    fields;
        int    first;
        int    second;
        int    third;
        int    program_length;
        string line;
        prog_write     = 1'b0;
        prog_address   = '0;
        prog_data      = '0;
        run            = 1'b0;
        n_channels     = count_width'(1);
        read_channel   = '0;
        read_register  = '0;
        program_length = 0;
        void'($urandom(32'hc3f6));
        compute_cycle_limit();
        fd = $fopen(input_file, "r");
        if (fd == 0) begin
            $display("Could not open %s for reading", input_file);
            other_errors++;
        end else begin
            wait (rst_n === 1'b1);
            while ($fgets(line, fd) != 0) begin
                case (line.getc(0))
                    "W": begin
                        fields = $sscanf(line, "W %h %h", first, second);
                        if (fields != 2) begin
                            $display("Malformed program word record: %s", line);
                            other_errors++;
                        end else begin
                            load_word(first, second);
                            if (first + 1 > program_length) begin
                                program_length = first + 1;
                            end
                        end
                    end
                    "R": begin
                        fields = $sscanf(line, "R %d %d", first, second);
                        if (fields != 2 || first < 1 || first > max_channels) begin
                            $display("Malformed run record: %s", line);
                            other_errors++;
                        end else begin
                            start_run(first);
                            compare_done(program_length * first + done_margin, second);
                        end
                    end
                    "E": begin
                        fields = $sscanf(line, "E %d %d %h", first, second, third);
                        if (fields != 3) begin
                            $display("Malformed expected value record: %s", line);
                            other_errors++;
                        end else begin
                            check_register(first, second, fcore_pkg::word_t'(third));
                        end
                    end
                    default: begin
                        // Comments and blank lines carry no record
                    end
                endcase
            end
            $fclose(fd);
        end
        report_counts();
        if (mismatch_errors + done_errors + other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- fetch_core_checker.sv
// Concurrent assertions on the done strobe, the issued channel range and the idle skip flag
`timescale 1ns/1ps

module fetch_core_checker #(
    parameter int max_channels = 4
) (
    input logic                                clock,
    input logic                                rst_n,
    input logic                                run,
    input logic                                done,
    input logic                                fetch_valid,
    input logic                                immediate_advance,
    input logic                                issue_valid,
    input logic [$clog2(max_channels)-1:0]     issue_channel,
    input logic [$clog2(max_channels + 1)-1:0] n_channels
);

    // Done is a single-cycle strobe, FINISH lasts exactly one cycle
    done_single_cycle: assert property (
        @(posedge clock) disable iff (!rst_n) done |=> !done
    ) else $error("done was high on two consecutive cycles");

    // The channel sweep never goes past the active channel count
    issue_channel_range: assert property (
        @(posedge clock) disable iff (!rst_n) issue_valid |-> (issue_channel < n_channels)
    ) else $error("issued channel %0d is not below n_channels %0d", issue_channel, n_channels);

    // A skip request belongs to a sweep that a run strobe started
    // An idle sequencer has seen no run in the cycle before and was not fetching
    no_skip_when_idle: assert property (
        @(posedge clock) disable iff (!rst_n)
        immediate_advance |-> ($past(run) || $past(fetch_valid))
    ) else $error("immediate_advance raised while the sequencer was idle");

endmodule

bind fetch_core_top fetch_core_checker #(
    .max_channels      (max_channels)
) u_fetch_core_checker (
    .clock             (clock),
    .rst_n             (rst_n),
    .run               (run),
    .done              (done),
    .fetch_valid       (fetch_valid),
    .immediate_advance (immediate_advance),
    .issue_valid       (issue_valid),
    .issue_channel     (issue_channel),
    .n_channels        (n_channels)
);

//--- tb_clock_gen.sv
// Testbench clock source with a 10 ns period and a synchronous reset held for two cycles
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int reset_cycles = 2
) (
    output logic clock,
    output logic rst_n
);

    // Half of the 10 ns period
    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    // Reset is released on a falling edge, half a cycle away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

//--- fetch_core_top.sv
// Top level joining program memory, sequencer, prefetcher and channel register file
`timescale 1ns/1ps

module fetch_core_top #(
    parameter int program_depth = fcore_pkg::DEFAULT_PROGRAM_DEPTH,
    parameter int max_channels  = fcore_pkg::DEFAULT_MAX_CHANNELS
) (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                prog_write,
    input  logic [$clog2(program_depth)-1:0]    prog_address,
    input  fcore_pkg::word_t                    prog_data,
    input  logic                                run,
    input  logic [$clog2(max_channels + 1)-1:0] n_channels,
    output logic                                done,
    input  logic [$clog2(max_channels)-1:0]     read_channel,
    input  fcore_pkg::reg_index_t               read_register,
    output fcore_pkg::word_t                    read_data
);

    localparam int addr_width    = $clog2(program_depth);
    localparam int channel_width = $clog2(max_channels);

    // Fetch stage, from the sequencer through memory to the prefetcher
    logic [addr_width-1:0]    fetch_address;
    logic [channel_width-1:0] fetch_channel;
    logic                     fetch_valid;
    fcore_pkg::word_t [1:0]   fetch_pair;

    // Flags fed back from the prefetcher to the sequencer
    logic immediate_advance;
    logic stop_call;

    // Issue stage into the register file
    fcore_pkg::word_t         issue_instruction;
    fcore_pkg::word_t         issue_constant;
    logic [channel_width-1:0] issue_channel;
    logic                     issue_valid;

    program_memory #(
        .program_depth (program_depth)
    ) u_program_memory (
        .clock         (clock),
        .prog_write    (prog_write),
        .prog_address  (prog_address),
        .prog_data     (prog_data),
        .fetch_address (fetch_address),
        .fetch_pair    (fetch_pair)
    );

    program_sequencer #(
        .program_depth     (program_depth),
        .max_channels      (max_channels)
    ) u_program_sequencer (
        .clock             (clock),
        .rst_n             (rst_n),
        .run               (run),
        .n_channels        (n_channels),
        .immediate_advance (immediate_advance),
        .stop_call         (stop_call),
        .fetch_address     (fetch_address),
        .fetch_channel     (fetch_channel),
        .fetch_valid       (fetch_valid),
        .done              (done)
    );

    instruction_prefetcher #(
        .max_channels      (max_channels)
    ) u_instruction_prefetcher (
        .clock             (clock),
        .rst_n             (rst_n),
        .fetch_pair        (fetch_pair),
        .fetch_channel     (fetch_channel),
        .fetch_valid       (fetch_valid),
        .n_channels        (n_channels),
        .issue_instruction (issue_instruction),
        .issue_constant    (issue_constant),
        .issue_channel     (issue_channel),
        .issue_valid       (issue_valid),
        .immediate_advance (immediate_advance),
        .stop_call         (stop_call)
    );

    channel_register_file #(
        .max_channels      (max_channels)
    ) u_channel_register_file (
        .clock             (clock),
        .rst_n             (rst_n),
        .issue_instruction (issue_instruction),
        .issue_constant    (issue_constant),
        .issue_channel     (issue_channel),
        .issue_valid       (issue_valid),
        .read_channel      (read_channel),
        .read_register     (read_register),
        .read_data         (read_data)
    );

endmodule

//--- channel_register_file.sv
// Per-channel register banks with LDC, MOV and ADD execution and a host readback port
`timescale 1ns/1ps

module channel_register_file #(
    parameter int max_channels = 4
) (
    input  logic                            clock,
    input  logic                            rst_n,
    input  fcore_pkg::word_t                issue_instruction,
    input  fcore_pkg::word_t                issue_constant,
    input  logic [$clog2(max_channels)-1:0] issue_channel,
    input  logic                            issue_valid,
    input  logic [$clog2(max_channels)-1:0] read_channel,
    input  fcore_pkg::reg_index_t           read_register,
    output fcore_pkg::word_t                read_data
);

    localparam int reg_bits    = $bits(fcore_pkg::reg_index_t);
    localparam int n_registers = 2 ** reg_bits;

    // One bank of registers for every channel
    fcore_pkg::word_t registers [max_channels][n_registers];

    fcore_pkg::opcode_t    opcode;
    fcore_pkg::reg_index_t dest;
    fcore_pkg::reg_index_t src_a;
    fcore_pkg::reg_index_t src_b;
    fcore_pkg::word_t      operand_a;
    fcore_pkg::word_t      operand_b;
    fcore_pkg::word_t      result;
    logic                  write_enable;

    // Instruction fields
    assign opcode = fcore_pkg::opcode_t'(issue_instruction[fcore_pkg::OPCODE_WIDTH-1:0]);
    assign dest   = issue_instruction[fcore_pkg::DEST_LSB +: reg_bits];
    assign src_a  = issue_instruction[fcore_pkg::SRC_A_LSB +: reg_bits];
    assign src_b  = issue_instruction[fcore_pkg::SRC_B_LSB +: reg_bits];

    // Operands come from the issuing channel, so a write from the previous
    // cycle is already visible here
    assign operand_a = registers[issue_channel][src_a];
    assign operand_b = registers[issue_channel][src_b];

    always_comb begin
        result       = operand_a;
        write_enable = 1'b0;
        case (opcode)
            fcore_pkg::LDC: begin
                result       = issue_constant;
                write_enable = 1'b1;
            end
            fcore_pkg::MOV: begin
                write_enable = 1'b1;
            end
            fcore_pkg::ADD: begin
                // Carry out is dropped, the sum wraps at 16 bits
                result       = operand_a + operand_b;
                write_enable = 1'b1;
            end
            default: begin
                // NOP and any unused code leave the bank alone
                write_enable = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int ch = 0; ch < max_channels; ch++) begin
                for (int r = 0; r < n_registers; r++) begin
                    registers[ch][r] <= '0;
                end
            end
        end else if (issue_valid && write_enable) begin
            registers[issue_channel][dest] <= result;
        end
    end

    // Host readback, valid once done has pulsed
    assign read_data = registers[read_channel][read_register];

endmodule

//--- instruction_prefetcher.sv
// Instruction and constant split, load-constant blanking, skip and stop flags, issue register
`timescale 1ns/1ps

module instruction_prefetcher #(
    parameter int max_channels = 4
) (
    input  logic                                clock,
    input  logic                                rst_n,
    input  fcore_pkg::word_t [1:0]              fetch_pair,
    input  logic [$clog2(max_channels)-1:0]     fetch_channel,
    input  logic                                fetch_valid,
    input  logic [$clog2(max_channels + 1)-1:0] n_channels,
    output fcore_pkg::word_t                    issue_instruction,
    output fcore_pkg::word_t                    issue_constant,
    output logic [$clog2(max_channels)-1:0]     issue_channel,
    output logic                                issue_valid,
    output logic                                immediate_advance,
    output logic                                stop_call
);

    localparam int count_width = $clog2(max_channels + 1);

    fcore_pkg::opcode_t opcode;

    // High while an LDC and its constant are held for the later channels
    logic load_blanking;
    logic last_channel;

    // The opcode is decoded straight from memory so the sequencer can react this cycle
    assign opcode = fcore_pkg::opcode_t'(fetch_pair[0][fcore_pkg::OPCODE_WIDTH-1:0]);

    assign last_channel = count_width'(fetch_channel) == n_channels - count_width'(1);

    // Only the first channel of an LDC asks for the constant word to be skipped
    assign immediate_advance = fetch_valid && (opcode == fcore_pkg::LDC) && !load_blanking;

    // End of program, raised on the first channel that meets STOP
    assign stop_call = fetch_valid && (opcode == fcore_pkg::STOP);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            load_blanking <= 1'b0;
            issue_valid   <= 1'b0;
        end else begin
            issue_valid <= fetch_valid && !stop_call;
            if (fetch_valid) begin
                if (load_blanking && last_channel) begin
                    load_blanking <= 1'b0;
                end else if (immediate_advance && !last_channel) begin
                    // A single channel needs no blanking, the sweep is already over
                    load_blanking <= 1'b1;
                end
            end
        end
    end

    // Issue payload, one cycle behind the fetch
    always_ff @(posedge clock) begin
        issue_channel <= fetch_channel;
        if (fetch_valid && !load_blanking) begin
            issue_instruction <= fetch_pair[0];
            if (opcode == fcore_pkg::LDC) begin
                issue_constant <= fetch_pair[1];
            end
        end
    end

endmodule

//--- program_sequencer.sv
// Run control FSM with program counter, channel sweep, constant skip and done strobe
`timescale 1ns/1ps

module program_sequencer #(
    parameter int program_depth = 64,
    parameter int max_channels  = 4
) (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                run,
    input  logic [$clog2(max_channels + 1)-1:0] n_channels,
    input  logic                                immediate_advance,
    input  logic                                stop_call,
    output logic [$clog2(program_depth)-1:0]    fetch_address,
    output logic [$clog2(max_channels)-1:0]     fetch_channel,
    output logic                                fetch_valid,
    output logic                                done
);

    localparam int addr_width    = $clog2(program_depth);
    localparam int channel_width = $clog2(max_channels);
    localparam int count_width   = $clog2(max_channels + 1);

    fcore_pkg::seq_state_t state;

    // Program counter and the channel that is fetched this cycle
    logic [addr_width-1:0]    pc;
    logic [channel_width-1:0] channel;

    // Set when the first channel of the current instruction saw an LDC,
    // so the constant word after it must be stepped over
    logic skip_constant;

    logic last_channel;
    logic advance_two;

    // The channel index counts fastest, the program counter moves once per sweep
    assign last_channel = count_width'(channel) == n_channels - count_width'(1);

    // With a single channel the skip has to be taken from the live flag,
    // since the latched copy is not yet written on the first channel
    assign advance_two = (channel == '0) ? immediate_advance : skip_constant;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state         <= fcore_pkg::IDLE;
            pc            <= '0;
            channel       <= '0;
            skip_constant <= 1'b0;
        end else begin
            case (state)
                fcore_pkg::IDLE: begin
                    // Run is only honoured here, a strobe during a run is dropped
                    if (run) begin
                        state         <= fcore_pkg::RUN;
                        pc            <= '0;
                        channel       <= '0;
                        skip_constant <= 1'b0;
                    end
                end
                fcore_pkg::RUN: begin
                    if (stop_call) begin
                        // STOP is never issued, so fetching ends right here
                        state <= fcore_pkg::FINISH;
                    end else begin
                        if (channel == '0) begin
                            skip_constant <= immediate_advance;
                        end
                        if (last_channel) begin
                            channel <= '0;
                            pc      <= advance_two ? pc + addr_width'(2) : pc + addr_width'(1);
                        end else begin
                            channel <= channel + 1'b1;
                        end
                    end
                end
                fcore_pkg::FINISH: begin
                    // One cycle here, the last issue has written by now
                    state <= fcore_pkg::IDLE;
                end
                default: begin
                    state <= fcore_pkg::IDLE;
                end
            endcase
        end
    end

    assign fetch_address = pc;
    assign fetch_channel = channel;

    // Both strobes are plain state decodes of a register
    assign fetch_valid = (state == fcore_pkg::RUN);
    assign done        = (state == fcore_pkg::FINISH);

endmodule

//--- program_memory.sv
// Program store with a host write port and a combinational two-word fetch port
`timescale 1ns/1ps

module program_memory #(
    parameter int program_depth = 64
) (
    input  logic                             clock,
    input  logic                             prog_write,
    input  logic [$clog2(program_depth)-1:0] prog_address,
    input  fcore_pkg::word_t                 prog_data,
    input  logic [$clog2(program_depth)-1:0] fetch_address,
    output fcore_pkg::word_t [1:0]           fetch_pair
);

    localparam int addr_width = $clog2(program_depth);

    // Program words, loaded by the host before a run
    fcore_pkg::word_t memory [program_depth];

    // Address of the word that follows the fetched one
    logic [addr_width-1:0] next_address;

    // Host writes land on the next rising edge
    always_ff @(posedge clock) begin
        if (prog_write) begin
            memory[prog_address] <= prog_data;
        end
    end

    // The second word wraps back to zero at the top of the array
    // This also covers depths that are not a power of two
    always_comb begin
        if (fetch_address == addr_width'(program_depth - 1)) begin
            next_address = '0;
        end else begin
            next_address = fetch_address + 1'b1;
        end
    end

    // Low half is the instruction word, high half the word after it
    // The prefetcher decides whether the high half is a constant
    assign fetch_pair[0] = memory[fetch_address];
    assign fetch_pair[1] = memory[next_address];

endmodule

//--- fcore_pkg.sv
// Shared word and register types, opcode and sequencer enums, field positions, default sizes
package fcore_pkg;

    // One program or data word as held in program memory and in the registers
    typedef logic [15:0] word_t;

    // Opcode field width, taken from the low bits of every instruction
    localparam int OPCODE_WIDTH = 5;

    // Instruction set of the execution slice
    // Any encoding not listed here behaves like NOP in the register file
    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP  = 5'd0,
        LDC  = 5'd1,
        MOV  = 5'd2,
        ADD  = 5'd3,
        STOP = 5'd4
    } opcode_t;

    // Register number inside the bank of one channel
    typedef logic [2:0] reg_index_t;

    // Lowest bit of each register field in an instruction
    // Bits 15:14 carry nothing
    localparam int DEST_LSB  = 5;
    localparam int SRC_A_LSB = 8;
    localparam int SRC_B_LSB = 11;

    // Run control states of the program sequencer
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        RUN    = 2'd1,
        FINISH = 2'd2
    } seq_state_t;

    // Sizes used when the top level is not told otherwise
    localparam int DEFAULT_PROGRAM_DEPTH = 64;
    localparam int DEFAULT_MAX_CHANNELS  = 4;

endpackage
